// File: verilog/qspim_bus_pkg.sv
`default_nettype none

package qspim_bus_pkg;

    // ------------------------------------------------------------------------
    // Ports and queues
    // ------------------------------------------------------------------------
    localparam int NUM_PORTS      = 2;          // Direct + indirect
    localparam int CMD_FIFO_DEPTH = 4;          // Entries per command FIFO

    // Register word indexes, reg_sel = 1
    localparam logic [3:0] REG_CFG      = 4'd0;
    localparam logic [3:0] REG_IND_ADDR = 4'd1; // Write starts port-1 read
    localparam logic [3:0] REG_IND_DATA = 4'd2; // Port-1 result
    localparam logic [3:0] REG_STATUS   = 4'd3; // {valid, pending}

    // Cmd 0x03, single lane, no dummy
    localparam logic [31:0] CFG_RESET = 32'h0000_0003;

    // Memory window view of the address
    typedef struct packed {
        logic [3:0]  rsvd_hi;
        logic        reg_sel;                   // 0 here
        logic [2:0]  rsvd;
        logic [23:0] flash_addr;
    } wb_mem_addr_t;

    // Register view of the same word
    typedef struct packed {
        logic [3:0]  rsvd_hi;
        logic        reg_sel;                   // 1 here
        logic [20:0] rsvd;
        logic [3:0]  reg_idx;
        logic [1:0]  byte_off;
    } wb_reg_addr_t;

    typedef union packed {
        wb_mem_addr_t mem;
        wb_reg_addr_t regs;
    } wb_addr_u;

    // Configuration register layout
    typedef struct packed {
        logic [15:0] rsvd_hi;
        logic [3:0]  dummy_cnt;                 // Bits 15:12
        logic [2:0]  rsvd_lo;
        logic        quad;                      // Bit 8
        logic [7:0]  cmd;                       // Flash read opcode
    } cfg_reg_t;

endpackage

`default_nettype wire

// File: verilog/qspim_spi_pkg.sv
`default_nettype none

package qspim_spi_pkg;

    localparam int SPI_CLK_DIV  = 2;            // mclk per sclk half period
    localparam int FLASH_ADDR_W = 24;
    localparam int DUMMY_W      = 4;

    // One queued flash read, 37 bits
    typedef struct packed {
        logic [FLASH_ADDR_W-1:0] flash_addr;
        logic [7:0]              cmd;
        logic                    quad;          // Addr and data on 4 lanes
        logic [DUMMY_W-1:0]      dummy_cnt;     // sclk periods
    } spi_cmd_t;

    // Controller result, valid is a pulse
    typedef struct packed {
        logic        valid;
        logic        port;                      // Owner of the result
        logic [31:0] data;                      // First byte in 7:0
    } spi_rsp_t;

    // ------------------------------------------------------------------------
    // Pad side
    // ------------------------------------------------------------------------
    typedef struct packed {
        logic       sclk;
        logic       csn;
        logic [3:0] sdo;
        logic [3:0] oen;                        // Active low per lane
    } spi_pad_out_t;

endpackage

`default_nettype wire

// File: verilog/qspim_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module qspim_fifo #(
    parameter int DEPTH = 4                             // Power of two
) (
    input  logic                    mclk,
    input  logic                    rst_i,
    input  logic                    push_i,             // Not while full
    input  qspim_spi_pkg::spi_cmd_t din_i,
    input  logic                    pop_i,
    output qspim_spi_pkg::spi_cmd_t dout_o,             // Show-ahead
    output logic                    full_o,
    output logic                    empty_o
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    qspim_spi_pkg::spi_cmd_t mem [DEPTH];
    logic [PTR_W-1:0]        wr_ptr_q;
    logic [PTR_W-1:0]        rd_ptr_q;
    logic [PTR_W:0]          cnt_q;                     // Entries held

    // Storage, no reset
    always_ff @(posedge mclk) begin
        if (push_i) mem[wr_ptr_q] <= din_i;
    end

    always_ff @(posedge mclk) begin
        if (rst_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            cnt_q    <= '0;
        end else begin
            if (push_i) wr_ptr_q <= wr_ptr_q + 1'b1;    // Wraps at DEPTH
            if (pop_i)  rd_ptr_q <= rd_ptr_q + 1'b1;
            if (push_i && !pop_i)      cnt_q <= cnt_q + 1'b1;
            else if (pop_i && !push_i) cnt_q <= cnt_q - 1'b1;
        end
    end

    assign dout_o  = mem[rd_ptr_q];
    assign full_o  = (cnt_q == (PTR_W+1)'(DEPTH));
    assign empty_o = (cnt_q == '0);

endmodule

`default_nettype wire

// File: verilog/qspim_wb_if.sv
`timescale 1ns/1ps
`default_nettype none

module qspim_wb_if (
    input  logic                                 mclk,
    input  logic                                 rst_i,
    // Wishbone slave
    input  logic                                 wbd_stb_i,
    input  qspim_bus_pkg::wb_addr_u              wbd_adr_i,
    input  logic                                 wbd_we_i,
    input  logic [31:0]                          wbd_dat_i,
    input  logic [3:0]                           wbd_sel_i,
    output logic [31:0]                          wbd_dat_o,
    output logic                                 wbd_ack_o,
    // Command FIFOs
    output logic [qspim_bus_pkg::NUM_PORTS-1:0]  cmd_push_o,
    output qspim_spi_pkg::spi_cmd_t              cmd_o [qspim_bus_pkg::NUM_PORTS],
    input  logic [qspim_bus_pkg::NUM_PORTS-1:0]  cmd_full_i,
    // From controller
    input  qspim_spi_pkg::spi_rsp_t              rsp_i
);

    qspim_bus_pkg::cfg_reg_t cfg_q;
    logic        ack_q;
    logic [31:0] dat_q;
    logic        mem_pushed_q;                  // Direct read in flight
    logic        ind_pend_q;
    logic        ind_vld_q;
    logic [31:0] ind_data_q;
    logic [31:0] rd_data;
    logic        req;
    logic        reg_acc;
    logic [3:0]  idx;
    logic        rsp0;
    logic        rsp1;

    assign req     = wbd_stb_i && !ack_q;       // Not yet acked
    assign reg_acc = wbd_adr_i.regs.reg_sel;
    assign idx     = wbd_adr_i.regs.reg_idx;
    assign rsp0    = rsp_i.valid && !rsp_i.port;
    assign rsp1    = rsp_i.valid && rsp_i.port;

    // ------------------------------------------------------------------------
    // Command push, one per direct strobe or IND_ADDR write
    // ------------------------------------------------------------------------
    assign cmd_push_o[0] = req && !reg_acc && !wbd_we_i && !mem_pushed_q && !cmd_full_i[0];
    assign cmd_push_o[1] = req && reg_acc && wbd_we_i &&
                           (idx == qspim_bus_pkg::REG_IND_ADDR) && !cmd_full_i[1];

    assign cmd_o[0] = '{flash_addr: wbd_adr_i.mem.flash_addr, cmd: cfg_q.cmd,
                        quad: cfg_q.quad, dummy_cnt: cfg_q.dummy_cnt};
    assign cmd_o[1] = '{flash_addr: wbd_dat_i[qspim_spi_pkg::FLASH_ADDR_W-1:0],
                        cmd: cfg_q.cmd, quad: cfg_q.quad, dummy_cnt: cfg_q.dummy_cnt};

    // Register read mux
    always_comb begin
        case (idx)
            qspim_bus_pkg::REG_CFG:      rd_data = cfg_q;
            qspim_bus_pkg::REG_IND_DATA: rd_data = ind_vld_q ? ind_data_q : rsp_i.data;
            qspim_bus_pkg::REG_STATUS:   rd_data = {30'b0, ind_vld_q, ind_pend_q};
            default:                     rd_data = '0;  // IND_ADDR reads zero
        endcase
    end

    always_ff @(posedge mclk) begin
        if (rst_i) begin
            ack_q        <= 1'b0;
            cfg_q        <= qspim_bus_pkg::CFG_RESET;
            mem_pushed_q <= 1'b0;
            ind_pend_q   <= 1'b0;
            ind_vld_q    <= 1'b0;
        end else begin
            ack_q <= 1'b0;
            if (rsp1) begin                     // Port-1 result lands
                ind_pend_q <= 1'b0;
                ind_vld_q  <= 1'b1;
            end
            if (cmd_push_o[0]) mem_pushed_q <= 1'b1;
            if (cmd_push_o[1]) begin            // New indirect read
                ind_pend_q <= 1'b1;
                ind_vld_q  <= 1'b0;
                ack_q      <= 1'b1;
            end
            if (req && !reg_acc) begin
                if (wbd_we_i) begin
                    ack_q <= 1'b1;              // Window is read only
                end else if (rsp0 && mem_pushed_q) begin
                    ack_q        <= 1'b1;
                    mem_pushed_q <= 1'b0;
                end
            end
            if (req && reg_acc) begin
                case (idx)
                    qspim_bus_pkg::REG_CFG: begin
                        ack_q <= 1'b1;
                        if (wbd_we_i) begin
                            for (int b = 0; b < 4; b++) begin
                                if (wbd_sel_i[b]) cfg_q[8*b +: 8] <= wbd_dat_i[8*b +: 8];
                            end
                        end
                    end
                    qspim_bus_pkg::REG_IND_ADDR: begin
                        if (!wbd_we_i) ack_q <= 1'b1;   // Write acks on push
                    end
                    qspim_bus_pkg::REG_IND_DATA: begin
                        if (wbd_we_i || ind_vld_q || rsp1) begin
                            ack_q <= 1'b1;
                            if (!wbd_we_i) ind_vld_q <= 1'b0;
                        end
                    end
                    default: ack_q <= 1'b1;
                endcase
            end
        end
    end

    // Read data and indirect result
    always_ff @(posedge mclk) begin
        if (rsp1) ind_data_q <= rsp_i.data;
        dat_q <= reg_acc ? rd_data : rsp_i.data;
    end

    assign wbd_ack_o = ack_q;
    assign wbd_dat_o = dat_q;

endmodule

`default_nettype wire

// File: verilog/qspim_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module qspim_ctrl (
    input  logic                                 mclk,
    input  logic                                 rst_i,
    input  qspim_spi_pkg::spi_cmd_t              cmd_i [qspim_bus_pkg::NUM_PORTS],
    input  logic [qspim_bus_pkg::NUM_PORTS-1:0]  cmd_empty_i,
    output logic [qspim_bus_pkg::NUM_PORTS-1:0]  cmd_pop_o,
    output qspim_spi_pkg::spi_rsp_t              rsp_o,
    output qspim_spi_pkg::spi_pad_out_t          spi_pad_o,
    input  logic [3:0]                           spi_sdi_i
);

    localparam int DIV_W = $clog2(qspim_spi_pkg::SPI_CLK_DIV) + 1;

    typedef enum logic [2:0] {
        ST_IDLE, ST_CMD, ST_ADDR, ST_DUMMY, ST_DATA, ST_DONE
    } state_t;

    state_t                             state_q;
    state_t                             nxt_state;
    logic [DIV_W-1:0]                   div_q;
    logic                               tick;       // Half period over
    logic                               sclk_q;
    logic                               csn_q;
    logic [4:0]                         bit_cnt_q;  // Periods left in phase
    logic [4:0]                         nxt_cnt;
    logic [4:0]                         data_cnt;
    logic                               quad_q;
    logic [qspim_spi_pkg::DUMMY_W-1:0]  dummy_q;
    logic                               port_q;
    logic [31:0]                        sft_q;      // {cmd, addr} out
    logic [31:0]                        rx_q;
    logic                               rsp_vld_q;
    logic                               rsp_port_q;
    logic [31:0]                        rsp_data_q;
    logic                               any_req;
    logic                               sel_port;
    logic                               quad_io;
    logic                               quad_rx;
    logic                               drv_lane0;

    // ------------------------------------------------------------------------
    // Fixed priority, lowest port wins
    // ------------------------------------------------------------------------
    always_comb begin
        any_req  = 1'b0;
        sel_port = 1'b0;
        for (int p = qspim_bus_pkg::NUM_PORTS - 1; p >= 0; p--) begin
            if (!cmd_empty_i[p]) begin
                any_req  = 1'b1;
                sel_port = 1'(p);
            end
        end
        for (int p = 0; p < qspim_bus_pkg::NUM_PORTS; p++) begin
            cmd_pop_o[p] = (state_q == ST_IDLE) && any_req && (sel_port == 1'(p));
        end
    end

    assign tick     = (div_q == DIV_W'(qspim_spi_pkg::SPI_CLK_DIV - 1));
    assign data_cnt = quad_q ? 5'd7 : 5'd31;

    // Next phase and its period count
    always_comb begin
        nxt_state = ST_DONE;
        nxt_cnt   = 5'd1;                       // DONE holds csn one period
        case (state_q)
            ST_CMD: begin
                nxt_state = ST_ADDR;
                nxt_cnt   = quad_q ? 5'd5 : 5'd23;
            end
            ST_ADDR: begin
                nxt_state = (dummy_q != '0) ? ST_DUMMY : ST_DATA;
                nxt_cnt   = (dummy_q != '0) ? 5'(dummy_q) - 5'd1 : data_cnt;
            end
            ST_DUMMY: begin
                nxt_state = ST_DATA;
                nxt_cnt   = data_cnt;
            end
            default: ;
        endcase
    end

    always_ff @(posedge mclk) begin
        if (rst_i) begin
            state_q   <= ST_IDLE;
            div_q     <= '0;
            sclk_q    <= 1'b0;
            csn_q     <= 1'b1;
            bit_cnt_q <= '0;
            quad_q    <= 1'b0;
            dummy_q   <= '0;
            port_q    <= 1'b0;
            sft_q     <= '0;
        end else begin
            div_q <= (state_q == ST_IDLE || tick) ? '0 : div_q + 1'b1;
            case (state_q)
                ST_IDLE: if (any_req) begin     // Pop and latch
                    state_q   <= ST_CMD;
                    csn_q     <= 1'b0;
                    bit_cnt_q <= 5'd7;
                    port_q    <= sel_port;
                    quad_q    <= cmd_i[sel_port].quad;
                    dummy_q   <= cmd_i[sel_port].dummy_cnt;
                    sft_q     <= {cmd_i[sel_port].cmd, cmd_i[sel_port].flash_addr};
                end
                ST_DONE: if (tick) begin        // csn high gap
                    if (bit_cnt_q == '0) state_q <= ST_IDLE;
                    else bit_cnt_q <= bit_cnt_q - 1'b1;
                end
                default: if (tick) begin
                    sclk_q <= !sclk_q;
                    if (sclk_q) begin           // Falling edge, next bits out
                        sft_q <= quad_io ? sft_q << 4 : sft_q << 1;
                        if (bit_cnt_q != '0) begin
                            bit_cnt_q <= bit_cnt_q - 1'b1;
                        end else begin
                            state_q   <= nxt_state;
                            bit_cnt_q <= nxt_cnt;
                            if (nxt_state == ST_DONE) csn_q <= 1'b1;
                        end
                    end
                end
            endcase
        end
    end

    // Sample on rising edge, MSB first per byte
    always_ff @(posedge mclk) begin
        if (tick && !sclk_q && state_q == ST_DATA) begin
            rx_q <= quad_q ? {rx_q[27:0], spi_sdi_i} : {rx_q[30:0], spi_sdi_i[1]};
        end
        rsp_port_q <= port_q;
        rsp_data_q <= {rx_q[7:0], rx_q[15:8], rx_q[23:16], rx_q[31:24]};
    end

    always_ff @(posedge mclk) begin
        if (rst_i) rsp_vld_q <= 1'b0;
        else       rsp_vld_q <= (state_q == ST_DONE) && (div_q == '0) && (bit_cnt_q == 5'd1);
    end

    assign rsp_o = '{valid: rsp_vld_q, port: rsp_port_q, data: rsp_data_q};

    // ------------------------------------------------------------------------
    // Lane drive, WP#/HOLD# high unless quad turns lanes around
    // ------------------------------------------------------------------------
    assign drv_lane0 = (state_q == ST_CMD) || (state_q == ST_ADDR);
    assign quad_io   = quad_q && (state_q == ST_ADDR);
    assign quad_rx   = quad_q && (state_q == ST_DUMMY || state_q == ST_DATA);

    assign spi_pad_o = '{sclk: sclk_q,
                         csn:  csn_q,
                         sdo:  quad_io ? sft_q[31:28] : {2'b11, 1'b0, sft_q[31]},
                         oen:  {quad_rx, quad_rx, !quad_io, !drv_lane0}};

endmodule

`default_nettype wire

// File: verilog/qspim_top.sv
`timescale 1ns/1ps
`default_nettype none

module qspim_top (
    input  logic                        mclk,
    input  logic                        rst_i,
    // Wishbone slave
    input  logic                        wbd_stb_i,
    input  qspim_bus_pkg::wb_addr_u     wbd_adr_i,
    input  logic                        wbd_we_i,
    input  logic [31:0]                 wbd_dat_i,
    input  logic [3:0]                  wbd_sel_i,
    output logic [31:0]                 wbd_dat_o,
    output logic                        wbd_ack_o,
    // Flash pads
    output qspim_spi_pkg::spi_pad_out_t spi_pad_o,
    input  logic [3:0]                  spi_sdi_i
);

    logic [qspim_bus_pkg::NUM_PORTS-1:0] cmd_push;
    logic [qspim_bus_pkg::NUM_PORTS-1:0] cmd_pop;
    logic [qspim_bus_pkg::NUM_PORTS-1:0] cmd_full;
    logic [qspim_bus_pkg::NUM_PORTS-1:0] cmd_empty;
    qspim_spi_pkg::spi_cmd_t             cmd_wr [qspim_bus_pkg::NUM_PORTS];
    qspim_spi_pkg::spi_cmd_t             cmd_rd [qspim_bus_pkg::NUM_PORTS];
    qspim_spi_pkg::spi_rsp_t             rsp;

    qspim_wb_if u_wb_if (
        .mclk       (mclk),
        .rst_i      (rst_i),
        .wbd_stb_i  (wbd_stb_i),
        .wbd_adr_i  (wbd_adr_i),
        .wbd_we_i   (wbd_we_i),
        .wbd_dat_i  (wbd_dat_i),
        .wbd_sel_i  (wbd_sel_i),
        .wbd_dat_o  (wbd_dat_o),
        .wbd_ack_o  (wbd_ack_o),
        .cmd_push_o (cmd_push),
        .cmd_o      (cmd_wr),
        .cmd_full_i (cmd_full),
        .rsp_i      (rsp)
    );

    // One command queue per port
    for (genvar k = 0; k < qspim_bus_pkg::NUM_PORTS; k++) begin : g_port
        qspim_fifo #(.DEPTH(qspim_bus_pkg::CMD_FIFO_DEPTH)) u_cmd_fifo (
            .mclk    (mclk),
            .rst_i   (rst_i),
            .push_i  (cmd_push[k]),
            .din_i   (cmd_wr[k]),
            .pop_i   (cmd_pop[k]),
            .dout_o  (cmd_rd[k]),
            .full_o  (cmd_full[k]),
            .empty_o (cmd_empty[k])
        );
    end

    qspim_ctrl u_ctrl (
        .mclk        (mclk),
        .rst_i       (rst_i),
        .cmd_i       (cmd_rd),
        .cmd_empty_i (cmd_empty),
        .cmd_pop_o   (cmd_pop),
        .rsp_o       (rsp),
        .spi_pad_o   (spi_pad_o),
        .spi_sdi_i   (spi_sdi_i)
    );

endmodule

`default_nettype wire

// File: tests/tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
    parameter int PERIOD_NS = 20
) (
    output logic clk_o
);

    initial clk_o = 1'b0;
    always #(PERIOD_NS / 2) clk_o = ~clk_o;     // 50% duty

endmodule

`default_nettype wire

// File: tests/spi_flash_model.sv
`timescale 1ns/1ps
`default_nettype none

module spi_flash_model (
    input  qspim_spi_pkg::spi_pad_out_t pad_i,
    output logic [3:0]                  sdi_o
);

    localparam int NO_DATA = 1000;          // Header length until decoded

    logic        sclk;
    logic        csn;
    logic [3:0]  sdo;
    logic [7:0]  cmd;
    logic [23:0] addr;
    logic [7:0]  cur;
    logic        quad;
    int          edge_cnt;                  // Rising sclk edges in frame
    int          addr_len;
    int          hdr_len;                   // Cmd + addr + dummy edges
    int          data_len;
    int          k;

    assign sclk = pad_i.sclk;
    assign csn  = pad_i.csn;
    assign sdo  = pad_i.sdo;

    // Array contents
    function automatic logic [7:0] byte_at(input logic [23:0] a);
        return a[7:0] ^ a[15:8] ^ 8'h5a;
    endfunction

    initial begin
        sdi_o    = 4'h0;
        edge_cnt = 0;
        addr_len = 24;
        data_len = 0;
        hdr_len  = NO_DATA;
        quad     = 1'b0;
    end

    always @(posedge csn) begin             // Frame over
        edge_cnt = 0;
        hdr_len  = NO_DATA;
    end

    // Opcode and address in on rising edges
    always @(posedge sclk) begin
        if (!csn) begin
            if (edge_cnt < 8) cmd = {cmd[6:0], sdo[0]};
            else if (edge_cnt < 8 + addr_len)
                addr = quad ? {addr[19:0], sdo} : {addr[22:0], sdo[0]};
            edge_cnt++;
            if (edge_cnt == 8) begin        // Mode from opcode
                quad     = (cmd == 8'heb);
                addr_len = quad ? 6 : 24;
                data_len = quad ? 8 : 32;
                case (cmd)
                    8'h0b:   hdr_len = 8 + 24 + 8;
                    8'heb:   hdr_len = 8 + 6 + 4;
                    default: hdr_len = 8 + 24;
                endcase
            end
        end
    end

    // Mode 0, next data bits after the falling edge
    always @(negedge sclk) begin
        if (!csn && edge_cnt >= hdr_len) begin
            k = edge_cnt - hdr_len;
            if (k < data_len) begin
                cur = byte_at(addr + 24'(quad ? k / 2 : k / 8));
                if (quad) sdi_o = (k % 2 == 0) ? cur[7:4] : cur[3:0];   // High nibble first
                else      sdi_o = {2'b00, cur[7 - k % 8], 1'b0};         // MISO on lane 1
            end
        end
    end

endmodule

`default_nettype wire

// File: tests/qspim_chk.sv
`timescale 1ns/1ps
`default_nettype none

module qspim_chk (
    input logic                        mclk,
    input logic                        rst_i,
    input logic                        stb_i,
    input logic                        ack_i,
    input qspim_spi_pkg::spi_pad_out_t pad_i
);

    int fail_cnt = 0;                       // Failed assertions so far

    // ------------------------------------------------------------------------
    // Wishbone
    // ------------------------------------------------------------------------
    ack_single: assert property (@(posedge mclk) disable iff (rst_i) ack_i |=> !ack_i)
        else begin
            $error("wbd_ack_o high on two consecutive cycles");
            fail_cnt++;
        end
    ack_has_stb: assert property (@(posedge mclk) disable iff (rst_i) ack_i |-> stb_i)
        else begin
            $error("wbd_ack_o without a strobe to answer");
            fail_cnt++;
        end

    // ------------------------------------------------------------------------
    // Pads
    // ------------------------------------------------------------------------
    sclk_idle: assert property (@(posedge mclk) disable iff (rst_i) pad_i.csn |-> !pad_i.sclk)
        else begin
            $error("sclk high while csn is high");
            fail_cnt++;
        end
    lane0_drive: assert property (@(posedge mclk) disable iff (rst_i)
                                  !pad_i.oen[0] |-> !pad_i.csn)
        else begin
            $error("lane 0 driven outside a frame");
            fail_cnt++;
        end

endmodule

`default_nettype wire

// File: tests/tb_qspim_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_qspim_top;

    // About 40 reads of up to ~300 cycles plus register traffic, with margin
    localparam int MAX_CYCLES = 20000;

    logic                        mclk;
    logic                        rst;
    logic                        stb;
    qspim_bus_pkg::wb_addr_u     adr;
    logic                        we;
    logic [31:0]                 dat_w;
    logic [3:0]                  sel;
    logic [31:0]                 dat_r;
    logic                        ack;
    qspim_spi_pkg::spi_pad_out_t pad;
    logic [3:0]                  sdi;

    integer      seed = 32'ha1f2_423f;
    int          cycle_cnt = 0;
    int          n_checks = 0;
    int          n_errors = 0;
    string       tag_q [$];                 // Pending compares
    logic [31:0] exp_q [$];
    logic [31:0] got_q [$];
    string       cmp_tag;
    logic [31:0] cmp_exp;
    logic [31:0] cmp_got;
    logic [23:0] a0;
    logic [23:0] a1;
    logic [31:0] rd;

    tb_clk_gen #(.PERIOD_NS(20)) u_clk (.clk_o(mclk));

    qspim_top u_qspim_top (
        .mclk      (mclk),
        .rst_i     (rst),
        .wbd_stb_i (stb),
        .wbd_adr_i (adr),
        .wbd_we_i  (we),
        .wbd_dat_i (dat_w),
        .wbd_sel_i (sel),
        .wbd_dat_o (dat_r),
        .wbd_ack_o (ack),
        .spi_pad_o (pad),
        .spi_sdi_i (sdi)
    );

    spi_flash_model u_flash (.pad_i(pad), .sdi_o(sdi));

    bind qspim_top qspim_chk u_chk (
        .mclk  (mclk),
        .rst_i (rst_i),
        .stb_i (wbd_stb_i),
        .ack_i (wbd_ack_o),
        .pad_i (spi_pad_o)
    );

    // ------------------------------------------------------------------------
    // Reference and helpers
    // ------------------------------------------------------------------------
    // Byte a is a[7:0] ^ a[15:8] ^ 0x5a, byte a lands in bits 7:0
    function automatic logic [31:0] ref_word(input logic [23:0] a);
        logic [31:0] w;
        logic [23:0] ab;
        for (int i = 0; i < 4; i++) begin
            ab          = a + 24'(i);
            w[8*i +: 8] = ab[7:0] ^ ab[15:8] ^ 8'h5a;
        end
        return w;
    endfunction

    function automatic qspim_bus_pkg::wb_addr_u reg_addr(input logic [3:0] idx);
        qspim_bus_pkg::wb_addr_u ad;
        ad              = '0;
        ad.regs.reg_sel = 1'b1;
        ad.regs.reg_idx = idx;
        return ad;
    endfunction

    function automatic logic [23:0] next_addr();
        return 24'($random(seed)) & 24'hff_fffc;   // Word aligned
    endfunction

    task automatic expect_value(input string what, input logic [31:0] exp,
                                input logic [31:0] got);
        tag_q.push_back(what);
        exp_q.push_back(exp);
        got_q.push_back(got);
    endtask

    // One Wishbone cycle, strobe held until ack
    task automatic bus_access(input qspim_bus_pkg::wb_addr_u a, input logic wr,
                              input logic [31:0] wdat, input logic [3:0] be,
                              output logic [31:0] rdat);
        @(negedge mclk);
        stb   = 1'b1;
        adr   = a;
        we    = wr;
        dat_w = wdat;
        sel   = be;
        do @(negedge mclk); while (!ack);
        rdat = dat_r;
        @(negedge mclk);                    // Dropped in the cycle after ack
        stb  = 1'b0;
        we   = 1'b0;
    endtask

    task automatic write_reg(input logic [3:0] idx, input logic [31:0] d, input logic [3:0] be);
        logic [31:0] unused;
        bus_access(reg_addr(idx), 1'b1, d, be, unused);
    endtask

    task automatic read_reg(input logic [3:0] idx, output logic [31:0] d);
        bus_access(reg_addr(idx), 1'b0, 32'h0, 4'hf, d);
    endtask

    task automatic read_flash_word(input logic [23:0] a, output logic [31:0] w);
        qspim_bus_pkg::wb_addr_u ad;
        ad                = '0;
        ad.mem.flash_addr = a;
        bus_access(ad, 1'b0, 32'h0, 4'hf, w);
    endtask

    task automatic direct_reads(input string mode, input logic [31:0] cfg_val);
        logic [23:0] a;
        logic [31:0] w;
        write_reg(qspim_bus_pkg::REG_CFG, cfg_val, 4'hf);
        for (int i = 0; i < 10; i++) begin
            a = next_addr();
            read_flash_word(a, w);
            expect_value($sformatf("%s read at %06h", mode, a), ref_word(a), w);
        end
    endtask

    task automatic wait_result();           // Poll STATUS valid
        logic [31:0] st;
        do read_reg(qspim_bus_pkg::REG_STATUS, st); while (!st[1]);
    endtask

    // ------------------------------------------------------------------------
    // Compare and timeout
    // ------------------------------------------------------------------------
    always @(negedge mclk) begin
        while (got_q.size() != 0) begin
            cmp_tag = tag_q.pop_front();
            cmp_exp = exp_q.pop_front();
            cmp_got = got_q.pop_front();
            n_checks++;
            assert (cmp_got === cmp_exp)
            else begin
                $display("** Error at %0t: %s, expected %08h, got %08h",
                         $time, cmp_tag, cmp_exp, cmp_got);
                n_errors++;
            end
        end
    end

    always @(posedge mclk) begin
        cycle_cnt++;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
            $display("Checks %0d, value errors %0d, assertion errors %0d, timeouts 1",
                     n_checks, n_errors, u_qspim_top.u_chk.fail_cnt);
            $display("Regression failed");
            $finish;
        end
    end

    // ------------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------------
    initial begin
        rst   = 1'b1;
        stb   = 1'b0;
        adr   = '0;
        we    = 1'b0;
        dat_w = '0;
        sel   = '0;
        repeat (16) @(negedge mclk);
        rst = 1'b0;
        @(negedge mclk);

        expect_value("ack after reset", 32'd0, 32'(ack));
        expect_value("csn after reset", 32'd1, 32'(pad.csn));
        expect_value("sclk after reset", 32'd0, 32'(pad.sclk));
        expect_value("oen after reset", 32'h3, 32'(pad.oen));      // Lanes 0/1 released
        expect_value("WP/HOLD after reset", 32'h3, 32'(pad.sdo[3:2]));
        read_reg(qspim_bus_pkg::REG_CFG, rd);
        expect_value("CFG after reset", qspim_bus_pkg::CFG_RESET, rd);

        write_reg(qspim_bus_pkg::REG_CFG, 32'ha5c3_3c5a, 4'hf);
        read_reg(qspim_bus_pkg::REG_CFG, rd);
        expect_value("CFG full write", 32'ha5c3_3c5a, rd);
        write_reg(qspim_bus_pkg::REG_CFG, 32'h1234_5678, 4'b0001);
        read_reg(qspim_bus_pkg::REG_CFG, rd);
        expect_value("CFG byte 0 write", 32'ha5c3_3c78, rd);

        direct_reads("0x03", 32'h0000_0003);
        direct_reads("0x0B", 32'h0000_800b);    // Dummy 8
        direct_reads("0xEB", 32'h0000_41eb);    // Quad, dummy 4

        // Indirect read on port 1
        a0 = next_addr();
        write_reg(qspim_bus_pkg::REG_IND_ADDR, {8'h00, a0}, 4'hf);
        read_reg(qspim_bus_pkg::REG_STATUS, rd);
        expect_value("STATUS while pending", 32'd1, rd);   // Transfer still running
        wait_result();
        read_reg(qspim_bus_pkg::REG_IND_DATA, rd);
        expect_value($sformatf("indirect read at %06h", a0), ref_word(a0), rd);
        read_reg(qspim_bus_pkg::REG_STATUS, rd);
        expect_value("STATUS after IND_DATA read", 32'd0, rd);

        // Both ports queued
        a0 = next_addr();
        a1 = next_addr();
        write_reg(qspim_bus_pkg::REG_IND_ADDR, {8'h00, a0}, 4'hf);
        read_flash_word(a1, rd);
        expect_value($sformatf("queued direct read at %06h", a1), ref_word(a1), rd);
        wait_result();
        read_reg(qspim_bus_pkg::REG_IND_DATA, rd);
        expect_value($sformatf("queued indirect read at %06h", a0), ref_word(a0), rd);

        repeat (4) @(negedge mclk);         // Drain compares
        $display("Checks %0d, value errors %0d, assertion errors %0d, timeouts 0",
                 n_checks, n_errors, u_qspim_top.u_chk.fail_cnt);
        if (n_errors == 0 && u_qspim_top.u_chk.fail_cnt == 0 && n_checks != 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
verilog/qspim_bus_pkg.sv
verilog/qspim_spi_pkg.sv
verilog/qspim_fifo.sv
verilog/qspim_wb_if.sv
verilog/qspim_ctrl.sv
verilog/qspim_top.sv
tests/tb_clk_gen.sv
tests/spi_flash_model.sv
tests/qspim_chk.sv
tests/tb_qspim_top.sv

// File: Bender.yml
package:
  name: qspim

sources:
  - files:
      - verilog/qspim_bus_pkg.sv
      - verilog/qspim_spi_pkg.sv
      - verilog/qspim_fifo.sv
      - verilog/qspim_wb_if.sv
      - verilog/qspim_ctrl.sv
      - verilog/qspim_top.sv
  - target: test
    files:
      - tests/tb_clk_gen.sv
      - tests/spi_flash_model.sv
      - tests/qspim_chk.sv
      - tests/tb_qspim_top.sv
